/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= vita_tx_tb
FILELIST  ?= sim.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/vita_tx_pkg.sv */
package vita_tx_pkg;

   localparam int SAMPLE_W    = 32;
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

   // Error kinds, low half of the error code
   localparam logic [15:0] CODE_UNDERRUN           = 16'd2;
   localparam logic [15:0] CODE_SEQ_ERROR          = 16'd4;
   localparam logic [15:0] CODE_TIME_ERROR         = 16'd8;
   localparam logic [15:0] CODE_UNDERRUN_MIDPKT    = 16'd16;
   localparam logic [15:0] CODE_SEQ_ERROR_MIDBURST = 16'd32;

   localparam logic [7:0] ADDR_CLEAR     = 8'd1;
   localparam logic [7:0] ADDR_POLICY    = 8'd3;
   localparam logic [7:0] ADDR_ERR_CLEAR = 8'd4;

   typedef struct packed {
      logic [31:0] data;
      logic        sof;
      logic        eof;
   } vita_word_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] sample;
      logic [63:0]         send_time;
      logic [15:0]         seqnum;
      logic                eop;
      logic                eob;
      logic                sob;
      logic                send_at;
      logic                seqnum_err;
   } sample_entry_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Bit 0 wait, bit 1 next packet, bit 2 next burst
   typedef struct packed {
      logic next_burst;
      logic next_packet;
      logic wait_en;
   } error_policy_t;

   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      RUN        = 3'd1,
      CONT_BURST = 3'd2,
      ERROR      = 3'd3,
      ERROR_DONE = 3'd4
   } tx_state_e;

endpackage

/* hw/vita_time_compare.sv */
module vita_time_compare (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic [63:0] time_now_i,
   input  logic [63:0] trigger_time_i,
   output logic        now_o,
   output logic        early_o,
   output logic        late_o
);

   logic hi_eq;
   logic hi_lt;
   logic lo_eq;
   logic lo_lt;

   // Halves compared separately, merged after the register
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         hi_eq <= 1'b0;
         hi_lt <= 1'b0;
         lo_eq <= 1'b0;
         lo_lt <= 1'b0;
      end
      else
      begin
         hi_eq <= time_now_i[63:32] == trigger_time_i[63:32];
         hi_lt <= time_now_i[63:32] < trigger_time_i[63:32];
         lo_eq <= time_now_i[31:0] == trigger_time_i[31:0];
         lo_lt <= time_now_i[31:0] < trigger_time_i[31:0];
      end
   end

   assign now_o   = hi_eq & lo_eq;
   assign early_o = hi_lt | (hi_eq & lo_lt);
   assign late_o  = ~now_o & ~early_o;

endmodule

/* hw/vita_tx_error_report.sv */
module vita_tx_error_report (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        err_clear_i,
   input  logic        err_stb_i,
   input  logic [31:0] err_code_i,
   output logic        error_o,
   output logic [31:0] last_code_o,
   output logic [15:0] err_count_o,
   output logic        sticky_o
);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         error_o     <= 1'b0;
         err_count_o <= 16'd0;
         sticky_o    <= 1'b0;
      end
      else
      begin
         error_o <= err_stb_i;    // Aligned with last_code_o
         if (err_clear_i)
         begin
            err_count_o <= 16'd0;
            sticky_o    <= 1'b0;
         end
         else if (err_stb_i)
         begin
            sticky_o <= 1'b1;
            if (err_count_o != 16'hffff)
               err_count_o <= err_count_o + 16'd1;   // Saturates
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (err_stb_i)
         last_code_o <= err_code_i;
   end

endmodule

/* hw/vita_tx_settings.sv */
module vita_tx_settings (
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  vita_tx_pkg::set_bus_t      set_i,
   output vita_tx_pkg::error_policy_t policy_o,
   output logic                       clear_o,
   output logic                       err_clear_o
);

   logic wr_clear;
   logic wr_policy;
   logic wr_err_clear;

   assign wr_clear     = set_i.stb && (set_i.addr == vita_tx_pkg::ADDR_CLEAR);
   assign wr_policy    = set_i.stb && (set_i.addr == vita_tx_pkg::ADDR_POLICY);
   assign wr_err_clear = set_i.stb && (set_i.addr == vita_tx_pkg::ADDR_ERR_CLEAR);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         policy_o    <= '0;
         clear_o     <= 1'b0;
         err_clear_o <= 1'b0;
      end
      else
      begin
         clear_o     <= wr_clear;      // One-cycle pulses
         err_clear_o <= wr_err_clear;
         if (wr_policy)
         begin
            policy_o <= vita_tx_pkg::error_policy_t'(set_i.data[2:0]);
         end
      end
   end

endmodule

/* hw/vita_tx_top.sv */
module vita_tx_top (
   input  logic                             clk,
   input  logic                             arst_n_i,
   input  vita_tx_pkg::set_bus_t            set_i,
   input  logic [63:0]                      vita_time_i,
   input  vita_tx_pkg::vita_word_t          frame_i,
   input  logic                             frame_valid_i,
   output logic                             frame_ready_o,
   output logic [vita_tx_pkg::SAMPLE_W-1:0] sample_o,
   output logic                             run_o,
   input  logic                             strobe_i,
   output logic                             error_o,
   output logic [31:0]                      last_code_o,
   output logic [15:0]                      err_count_o,
   output logic                             sticky_o
);

   vita_tx_pkg::error_policy_t policy;
   vita_tx_pkg::sample_entry_t head;
   logic                       clear;
   logic                       err_clear;
   logic                       src_rdy;
   logic                       dst_rdy;
   logic                       err_stb;
   logic [31:0]                err_code;

   vita_tx_settings settings_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .set_i       (set_i),
      .policy_o    (policy),
      .clear_o     (clear),
      .err_clear_o (err_clear)
   );

   vita_tx_deframer deframer_i (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .clear_i       (clear),
      .frame_i       (frame_i),
      .frame_valid_i (frame_valid_i),
      .frame_ready_o (frame_ready_o),
      .head_o        (head),
      .src_rdy_o     (src_rdy),
      .dst_rdy_i     (dst_rdy)
   );

   vita_tx_control control_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear),
      .policy_i    (policy),
      .vita_time_i (vita_time_i),
      .head_i      (head),
      .src_rdy_i   (src_rdy),
      .dst_rdy_o   (dst_rdy),
      .sample_o    (sample_o),
      .run_o       (run_o),
      .strobe_i    (strobe_i),
      .err_stb_o   (err_stb),
      .err_code_o  (err_code)
   );

   vita_tx_error_report report_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .err_clear_i (err_clear),
      .err_stb_i   (err_stb),
      .err_code_i  (err_code),
      .error_o     (error_o),
      .last_code_o (last_code_o),
      .err_count_o (err_count_o),
      .sticky_o    (sticky_o)
   );

endmodule

/* sim.f */
common/vita_tx_pkg.sv
hw/vita_tx_settings.sv
hw/vita_time_compare.sv
vita_tx_deframer/vita_tx_deframer.sv
vita_tx_control/vita_tx_control.sv
hw/vita_tx_error_report.sv
hw/vita_tx_top.sv
verif/vita_tx_asserts.sv
verif/vita_tx_tb.sv

/* verif/vita_tx_asserts.sv */
module vita_tx_asserts (
   input logic                   clk,
   input logic                   arst_n_i,
   input vita_tx_pkg::tx_state_e state_i,
   input logic                   dst_rdy_i,
   input logic                   err_stb_i,
   input logic                   run_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // Entries leave the queue only while draining or playing
   dst_rdy_in_run_or_error: assert property (@(posedge clk) disable iff (!arst_n_i)
      dst_rdy_i |-> (state_i == vita_tx_pkg::ERROR || state_i == vita_tx_pkg::RUN))
      else $error("dst_rdy_o high in state %0d", state_i);

   err_stb_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
      err_stb_i |=> !err_stb_i)
      else $error("err_stb_o held for more than one cycle");

   run_low_after_reset: assert property (@(posedge clk)
      $rose(arst_n_i) |-> !run_i)
      else $error("run_o high right after reset");

endmodule

bind vita_tx_control vita_tx_asserts asserts_i (
   .clk       (clk),
   .arst_n_i  (arst_n_i),
   .state_i   (state),
   .dst_rdy_i (dst_rdy_o),
   .err_stb_i (err_stb_o),
   .run_i     (run_o)
);

/* verif/vita_tx_tb.sv */
module vita_tx_tb;

   timeunit 1ns;
   timeprecision 1ps;

   logic                    clk;
   logic                    arst_n_i;
   vita_tx_pkg::set_bus_t   set_i;
   logic [63:0]             vita_time_i;
   vita_tx_pkg::vita_word_t frame_i;
   logic                    frame_valid_i;
   logic                    frame_ready_o;
   logic [31:0]             sample_o;
   logic                    run_o;
   logic                    strobe_i;
   logic                    error_o;
   logic [31:0]             last_code_o;
   logic [15:0]             err_count_o;
   logic                    sticky_o;

   logic [15:0] lfsr;
   logic [31:0] exp_samples [$];
   logic [31:0] exp_codes [$];
   logic [31:0] exp_s;
   logic [31:0] exp_c;
   logic [31:0] tail_word;
   logic        have_prev;
   logic [15:0] prev_seq;
   logic [63:0] t_send;
   int          exp_err_total;
   int          errors;
   int          checks;
   int          tests;
   int          tests_failed;
   int          mark;
   int          max_wait;

   vita_tx_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
      vita_time_i <= vita_time_i + 64'd1;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Error kind 0 in the expected outcome means the packet plays
   function automatic logic [31:0] ref_outcome(input logic hp, input logic [15:0] prev,
      input logic [15:0] seq, input logic send_at, input logic [63:0] ts, input logic [63:0] now);
      logic [15:0] kind;
      kind = 16'd0;
      if (hp && seq != prev + 16'd1)
         kind = 16'd4;
      else if (send_at && ts < now)
         kind = 16'd8;
      return {seq, kind};
   endfunction

   task automatic timed_out(input string what);
      $display("Timeout at %0t ns waiting for %s", $time, what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic send_word(input logic [31:0] w, input logic sof, input logic eof);
      int n;
      n = 0;
      frame_i       <= '{data: w, sof: sof, eof: eof};
      frame_valid_i <= 1'b1;
      @(posedge clk);
      while (!frame_ready_o)
      begin
         @(posedge clk);
         n++;
         if (n > max_wait)
            timed_out("frame_ready_o");
      end
   endtask

   task automatic send_packet(input logic [15:0] seq, input logic sob, input logic eob,
      input logic send_at, input logic [63:0] ts, input int n, input logic last_eof);
      logic [31:0] code;
      logic [31:0] s;
      code = ref_outcome(have_prev, prev_seq, seq, send_at, ts, vita_time_i);
      have_prev = 1'b1;
      prev_seq  = seq;
      if (code[15:0] != 16'd0)
      begin
         exp_codes.push_back(code);
         exp_err_total++;
      end
      send_word({13'd0, send_at, sob, eob, seq}, 1'b1, 1'b0);
      send_word(ts[63:32], 1'b0, 1'b0);
      send_word(ts[31:0], 1'b0, 1'b0);
      for (int i = 0; i < n; i++)
      begin
         rand_bits(32, s);
         if (code[15:0] == 16'd0)
            exp_samples.push_back(s);
         send_word(s, 1'b0, last_eof && (i == n - 1));
      end
      frame_valid_i <= 1'b0;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_i <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      set_i.stb <= 1'b0;
      @(posedge clk);
   endtask

   task automatic wait_run();
      int n;
      n = 0;
      while (!run_o)
      begin
         @(posedge clk);
         n++;
         if (n > max_wait)
            timed_out("run_o");
      end
   endtask

   // At least one idle cycle between strobes
   task automatic strobe_pulse();
      logic [31:0] gap;
      rand_bits(2, gap);
      repeat (gap + 1) @(posedge clk);
      wait_run();
      strobe_i <= 1'b1;
      @(posedge clk);
      strobe_i <= 1'b0;
   endtask

   task automatic strobe_samples(input int n);
      for (int i = 0; i < n; i++)
         strobe_pulse();
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_samples.size() != 0)
      begin
         @(posedge clk);
         n++;
         if (n > max_wait)
            timed_out("samples to leave");
      end
   endtask

   task automatic wait_codes();
      int n;
      n = 0;
      while (exp_codes.size() != 0)
      begin
         @(posedge clk);
         n++;
         if (n > max_wait)
            timed_out("error_o");
      end
   endtask

   task automatic wait_full();
      int n;
      n = 0;
      while (frame_ready_o)
      begin
         @(posedge clk);
         n++;
         if (n > max_wait)
            timed_out("frame_ready_o to fall");
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != mark)
         tests_failed++;
      $display("Test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "failed");
      mark = errors;
   endtask

   // Compares outputs against the expected queues
   always @(posedge clk)
   begin
      if (arst_n_i && strobe_i && run_o && exp_samples.size() != 0)
      begin
         exp_s = exp_samples.pop_front();
         checks++;
         assert (sample_o == exp_s)
         else
         begin
            errors++;
            $display("Error at %0t ns: sample_o is %h, expected %h", $time, sample_o, exp_s);
         end
      end
      if (arst_n_i && error_o)
      begin
         checks++;
         assert (exp_codes.size() != 0)
         else
         begin
            errors++;
            $display("Unexpected error pulse at %0t ns, code %h", $time, last_code_o);
         end
         if (exp_codes.size() != 0)
         begin
            exp_c = exp_codes.pop_front();
            assert (last_code_o == exp_c)
            else
            begin
               errors++;
               $display("Error at %0t ns: last_code_o is %h, expected %h",
                        $time, last_code_o, exp_c);
            end
         end
      end
   end

   initial
   begin
      arst_n_i      = 1'b0;
      set_i         = '0;
      vita_time_i   = 64'd0;
      frame_i       = '0;
      frame_valid_i = 1'b0;
      strobe_i      = 1'b0;
      lfsr          = 16'd45739;
      have_prev     = 1'b0;
      prev_seq      = 16'd0;
      exp_err_total = 0;
      errors        = 0;
      checks        = 0;
      tests         = 0;
      tests_failed  = 0;
      mark          = 0;
      max_wait      = 500;
      repeat (8) @(posedge clk);
      arst_n_i <= 1'b1;
      @(posedge clk);
      checks++;
      assert (frame_ready_o)
      else
      begin
         errors++;
         $display("Error at %0t ns: frame_ready_o is %b, expected 1", $time, frame_ready_o);
      end
      write_setting(vita_tx_pkg::ADDR_POLICY, 32'd2);   // next_packet

      send_packet(16'd1, 1'b1, 1'b0, 1'b0, 64'd0, 2, 1'b1);
      send_packet(16'd2, 1'b0, 1'b1, 1'b0, 64'd0, 2, 1'b1);
      strobe_samples(4);
      wait_drained();
      end_test("immediate burst");

      t_send = vita_time_i + 64'd60;
      send_packet(16'd3, 1'b1, 1'b1, 1'b1, t_send, 2, 1'b1);
      wait_run();
      checks++;
      assert (vita_time_i > t_send)
      else
      begin
         errors++;
         $display("Error at %0t ns: vita_time_i is %0d when run_o rose, expected above %0d",
                  $time, vita_time_i, t_send);
      end
      strobe_samples(2);
      wait_drained();
      send_packet(16'd4, 1'b1, 1'b1, 1'b1, vita_time_i - 64'd10, 2, 1'b1);
      wait_codes();
      end_test("timed and late");

      send_packet(16'd6, 1'b1, 1'b1, 1'b0, 64'd0, 2, 1'b1);
      send_packet(16'd7, 1'b1, 1'b1, 1'b0, 64'd0, 2, 1'b1);
      strobe_samples(2);
      wait_drained();
      wait_codes();
      end_test("sequence gap");

      send_packet(16'd8, 1'b1, 1'b0, 1'b0, 64'd0, 2, 1'b1);
      strobe_samples(2);
      wait_drained();
      exp_codes.push_back({16'd8, 16'd2});
      exp_err_total++;
      strobe_pulse();                                   // Nothing queued in CONT_BURST
      wait_codes();
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         checks++;
         assert (!run_o)
         else
         begin
            errors++;
            $display("Error at %0t ns: run_o is %b, expected 0", $time, run_o);
         end
      end
      write_setting(vita_tx_pkg::ADDR_CLEAR, 32'd0);
      have_prev = 1'b0;
      send_packet(16'd100, 1'b1, 1'b1, 1'b0, 64'd0, 2, 1'b1);
      strobe_samples(2);
      wait_drained();
      end_test("burst underrun");

      send_packet(16'd101, 1'b1, 1'b1, 1'b0, 64'd0, 1, 1'b0);
      strobe_samples(1);
      wait_drained();
      exp_codes.push_back({16'd101, 16'd16});
      exp_err_total++;
      strobe_pulse();
      wait_codes();
      rand_bits(32, tail_word);
      send_word(tail_word, 1'b0, 1'b1);                 // Rest of packet is drained
      frame_valid_i <= 1'b0;
      checks++;
      assert (err_count_o == 16'(exp_err_total))
      else
      begin
         errors++;
         $display("Error at %0t ns: err_count_o is %0d, expected %0d",
                  $time, err_count_o, exp_err_total);
      end
      checks++;
      assert (sticky_o)
      else
      begin
         errors++;
         $display("Error at %0t ns: sticky_o is %b, expected 1", $time, sticky_o);
      end
      write_setting(vita_tx_pkg::ADDR_ERR_CLEAR, 32'd0);
      for (int n = 0; err_count_o != 16'd0; n++)
      begin
         @(posedge clk);
         if (n > max_wait)
            timed_out("err_count_o to clear");
      end
      checks++;
      assert (!sticky_o)
      else
      begin
         errors++;
         $display("Error at %0t ns: sticky_o is %b, expected 0", $time, sticky_o);
      end
      end_test("packet underrun");

      fork
         send_packet(16'd102, 1'b1, 1'b1, 1'b0, 64'd0, 6, 1'b1);
         begin
            wait_full();
            strobe_samples(6);
         end
      join
      wait_drained();
      end_test("back-pressure");

      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* vita_tx_control/vita_tx_control.sv */
module vita_tx_control (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          clear_i,
   input  vita_tx_pkg::error_policy_t    policy_i,
   input  logic [63:0]                   vita_time_i,
   input  vita_tx_pkg::sample_entry_t    head_i,
   input  logic                          src_rdy_i,
   output logic                          dst_rdy_o,
   output logic [vita_tx_pkg::SAMPLE_W-1:0] sample_o,
   output logic                          run_o,
   input  logic                          strobe_i,
   output logic                          err_stb_o,
   output logic [31:0]                   err_code_o
);

   vita_tx_pkg::tx_state_e state;
   vita_tx_pkg::tx_state_e state_nx;
   logic        now;
   logic        late;
   logic        cmp_ok;      // Compare result belongs to current head
   logic        raise;
   logic        go_idle;
   logic [15:0] err_kind;
   logic [15:0] last_seq;
   logic [15:0] code_seq;

   vita_time_compare time_cmp_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .time_now_i     (vita_time_i),
      .trigger_time_i (head_i.send_time),
      .now_o          (now),
      .early_o        (),
      .late_o         (late)
   );

   assign go_idle  = ~policy_i.wait_en &
                     (policy_i.next_packet | (policy_i.next_burst & head_i.eob));
   assign code_seq = src_rdy_i ? head_i.seqnum : last_seq;

   always_comb
   begin
      state_nx = state;
      raise    = 1'b0;
      err_kind = vita_tx_pkg::CODE_UNDERRUN;
      case (state)
         vita_tx_pkg::IDLE:
            if (src_rdy_i)
            begin
               if (head_i.seqnum_err)
               begin
                  state_nx = vita_tx_pkg::ERROR;
                  raise    = 1'b1;
                  err_kind = vita_tx_pkg::CODE_SEQ_ERROR;
               end
               else if (!head_i.send_at || (cmp_ok && now))
                  state_nx = vita_tx_pkg::RUN;
               else if (cmp_ok && late)
               begin
                  state_nx = vita_tx_pkg::ERROR;
                  raise    = 1'b1;
                  err_kind = vita_tx_pkg::CODE_TIME_ERROR;
               end
            end
         vita_tx_pkg::RUN:
            if (strobe_i)
            begin
               if (!src_rdy_i)
               begin
                  state_nx = vita_tx_pkg::ERROR;
                  raise    = 1'b1;
                  err_kind = vita_tx_pkg::CODE_UNDERRUN_MIDPKT;
               end
               else if (head_i.eop)
                  state_nx = head_i.eob ? vita_tx_pkg::IDLE : vita_tx_pkg::CONT_BURST;
            end
         vita_tx_pkg::CONT_BURST:
            if (strobe_i)
            begin
               state_nx = vita_tx_pkg::ERROR_DONE;    // Gap between packets
               raise    = 1'b1;
            end
            else if (src_rdy_i)
            begin
               if (head_i.seqnum_err)
               begin
                  state_nx = vita_tx_pkg::ERROR;
                  raise    = 1'b1;
                  err_kind = vita_tx_pkg::CODE_SEQ_ERROR_MIDBURST;
               end
               else
                  state_nx = vita_tx_pkg::RUN;
            end
         vita_tx_pkg::ERROR:
            if (src_rdy_i && head_i.eop)
               state_nx = go_idle ? vita_tx_pkg::IDLE : vita_tx_pkg::ERROR_DONE;
         default:
            state_nx = state;    // ERROR_DONE waits for clear
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state     <= vita_tx_pkg::IDLE;
         err_stb_o <= 1'b0;
         cmp_ok    <= 1'b0;
      end
      else if (clear_i)
      begin
         state     <= vita_tx_pkg::IDLE;
         err_stb_o <= 1'b0;
         cmp_ok    <= 1'b0;
      end
      else
      begin
         state     <= state_nx;
         err_stb_o <= raise;
         cmp_ok    <= src_rdy_i & ~dst_rdy_o;
      end
   end

   always_ff @(posedge clk)
   begin
      if (src_rdy_i)
         last_seq <= head_i.seqnum;
      if (raise)
         err_code_o <= {code_seq, err_kind};
   end

   // Drain in ERROR, one pop per strobe in RUN
   assign dst_rdy_o = (state == vita_tx_pkg::ERROR) |
                      (strobe_i & (state == vita_tx_pkg::RUN));
   assign run_o     = (state == vita_tx_pkg::RUN) | (state == vita_tx_pkg::CONT_BURST);
   assign sample_o  = head_i.sample;

endmodule

/* vita_tx_deframer/vita_tx_deframer.sv */
module vita_tx_deframer (
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       clear_i,
   input  vita_tx_pkg::vita_word_t    frame_i,
   input  logic                       frame_valid_i,
   output logic                       frame_ready_o,
   output vita_tx_pkg::sample_entry_t head_o,
   output logic                       src_rdy_o,
   input  logic                       dst_rdy_i
);

   logic [1:0]  word_cnt;    // 0 header, 1 time hi, 2 time lo, 3 samples
   logic        accept;
   logic        is_hdr;
   logic        push;
   logic        pop;
   logic        full;
   logic        empty;
   logic        have_prev;
   logic [15:0] prev_seq;
   logic [15:0] ctx_seq;
   logic [63:0] ctx_time;
   logic        ctx_eob;
   logic        ctx_sob;
   logic        ctx_send_at;
   logic        ctx_seq_err;

   logic [vita_tx_pkg::QPTR_W:0] wr_ptr;
   logic [vita_tx_pkg::QPTR_W:0] rd_ptr;
   vita_tx_pkg::sample_entry_t   wr_entry;
   vita_tx_pkg::sample_entry_t   mem [vita_tx_pkg::QUEUE_DEPTH];

   assign accept = frame_valid_i & frame_ready_o;
   assign is_hdr = frame_i.sof | (word_cnt == 2'd0);   // sof resyncs the parser
   assign push   = accept & ~is_hdr & (word_cnt == 2'd3);
   assign pop    = ~empty & dst_rdy_i;

   assign empty = wr_ptr == rd_ptr;
   assign full  = (wr_ptr[vita_tx_pkg::QPTR_W] != rd_ptr[vita_tx_pkg::QPTR_W]) &&
                  (wr_ptr[vita_tx_pkg::QPTR_W-1:0] == rd_ptr[vita_tx_pkg::QPTR_W-1:0]);

   assign frame_ready_o = ~full;
   assign src_rdy_o     = ~empty;
   assign head_o        = mem[rd_ptr[vita_tx_pkg::QPTR_W-1:0]];

   always_comb
   begin
      wr_entry.sample     = frame_i.data;
      wr_entry.send_time  = ctx_time;
      wr_entry.seqnum     = ctx_seq;
      wr_entry.eop        = frame_i.eof;
      wr_entry.eob        = ctx_eob;
      wr_entry.sob        = ctx_sob;
      wr_entry.send_at    = ctx_send_at;
      wr_entry.seqnum_err = ctx_seq_err;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         word_cnt  <= 2'd0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         have_prev <= 1'b0;
      end
      else if (clear_i)
      begin
         word_cnt  <= 2'd0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         have_prev <= 1'b0;
      end
      else
      begin
         if (accept)
         begin
            if (is_hdr)
            begin
               word_cnt  <= 2'd1;
               have_prev <= 1'b1;
            end
            else if (word_cnt != 2'd3)
               word_cnt <= word_cnt + 2'd1;
            else if (frame_i.eof)
               word_cnt <= 2'd0;
         end
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept && is_hdr)
      begin
         ctx_seq     <= frame_i.data[15:0];
         ctx_eob     <= frame_i.data[16];
         ctx_sob     <= frame_i.data[17];
         ctx_send_at <= frame_i.data[18];
         // First packet after reset or clear is always good
         ctx_seq_err <= have_prev && (frame_i.data[15:0] != prev_seq + 16'd1);
         prev_seq    <= frame_i.data[15:0];
      end
      if (accept && !is_hdr && word_cnt == 2'd1)
         ctx_time[63:32] <= frame_i.data;
      if (accept && !is_hdr && word_cnt == 2'd2)
         ctx_time[31:0] <= frame_i.data;
      if (push)
         mem[wr_ptr[vita_tx_pkg::QPTR_W-1:0]] <= wr_entry;
   end

endmodule
